// File: testbench/gpio_patterns.txt
# W addr data | R addr expected | P pins tse | N cycles | O oe_n out irq
# every number is hex
# after reset
O ffff 0000 0
R 00 00000000
R 04 00000000
R 08 00000000
R 0C 00000000
R 10 00000000
R 14 00000000
R 18 00000000
# read-back, upper pwdata bits dropped
W 00 0000a5c3
W 04 ffff00ff
R 00 0000a5c3
R 04 000000ff
W 1C 00001234
R 1C 00000000
# output drive and tri-state override
O ff00 a5c3 0
P 0000 000f
N 4
O ff0f a5c3 0
P 0000 0000
N 4
O ff00 a5c3 0
# input path
P 3c5a 0000
N 4
R 08 00003c5a
# edge, rising on pins 0-3, falling on pins 4-7
W 10 000000ff
W 14 0000000f
W 0C 000000ff
N 4
R 18 00000000
P 3ca5 0000
N 6
R 18 00000055
O ff00 a5c3 1
W 0C 0000000a
O ff00 a5c3 0
W 0C 00000005
O ff00 a5c3 1
W 18 00000005
R 18 00000050
O ff00 a5c3 0
W 18 00000050
R 18 00000000
# level, active high on pins 10 and 11
W 0C 00000000
W 14 00000c0f
W 0C 00000c00
N 2
R 18 00000c00
O ff00 a5c3 1
W 18 00000c00
R 18 00000c00
P 30a5 0000
N 4
R 18 00000c00
W 18 00000c00
R 18 00000000
O ff00 a5c3 0

// File: sim.f
rtl/gpio_pkg.sv
rtl/gpio_int_detect.sv
rtl/gpio_lite_subunit.sv
rtl/gpio_lite.sv
testbench/gpio_lite_tb.sv

// File: Bender.yml
package:
  name: gpio_lite

sources:
  # rtl, package first
  - rtl/gpio_pkg.sv
  - rtl/gpio_int_detect.sv
  - rtl/gpio_lite_subunit.sv
  - rtl/gpio_lite.sv

  # testbench
  - target: test
    files:
      - testbench/gpio_lite_tb.sv

// File: testbench/gpio_lite_tb.sv
module gpio_lite_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import gpio_pkg::*;

   localparam int CLK_PERIOD      = 4;    // ns
   localparam int CYCLES_PER_LINE = 64;   // watchdog budget per command

   logic       pclk;
   logic       reset;
   logic       psel;
   logic       penable;
   logic       pwrite;
   apb_addr_t  paddr;
   apb_data_t  pwdata;
   apb_data_t  prdata;
   gpio_word_t gpio_pin_in;
   gpio_word_t tri_state_enable;
   logic       gpio_int;
   gpio_word_t n_gpio_pin_oe;
   gpio_word_t gpio_pin_out;

   // parsed pattern file with one entry per command
   byte       cmd_q [$];
   apb_data_t arg_a [$];
   apb_data_t arg_b [$];
   apb_data_t arg_c [$];

   bit loaded;      // releases the watchdog
   int errors;
   int checks;

   gpio_lite #(
      .SYNC_STAGES      (2)
   ) dut0 (
      .pclk             (pclk),
      .reset            (reset),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .prdata           (prdata),
      .gpio_pin_in      (gpio_pin_in),
      .tri_state_enable (tri_state_enable),
      .gpio_int         (gpio_int),
      .n_gpio_pin_oe    (n_gpio_pin_oe),
      .gpio_pin_out     (gpio_pin_out)
   );

   initial
   begin
      pclk = 1'b0;
      forever #(CLK_PERIOD/2) pclk = ~pclk;
   end

   // ---------------------------------------------------------------------
   // helpers
   // ---------------------------------------------------------------------
   task automatic step();   // next edge plus drive skew
      @(posedge pclk);
      #1;
   endtask

   task automatic check_word(input string name, input apb_data_t expected,
                             input apb_data_t actual);
      checks++;
      if (actual !== expected)
      begin
         $display("Fail %s: expected %h, got %h at %0t", name, expected, actual, $time);
         errors++;
      end
   endtask

   task automatic load_patterns();
      int        fd;
      int        r;
      int        want;
      int        ch;
      apb_data_t a;
      apb_data_t b;
      apb_data_t c;
      fd = $fopen("testbench/gpio_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("could not open testbench/gpio_patterns.txt");
         errors++;
         return;
      end
      while (!$feof(fd))
      begin
         r = $fscanf(fd, " %c", ch);   // command letter
         if (r != 1)
            break;
         a    = '0;
         b    = '0;
         c    = '0;
         want = 0;                     // fields expected after the letter
         case (ch)
            "#":
               while (ch != "\n" && ch != -1)
                  ch = $fgetc(fd);     // drop the rest of a comment line
            "W", "R", "P":
            begin
               want = 2;
               r    = $fscanf(fd, "%h %h", a, b);
            end
            "N":
            begin
               want = 1;
               r    = $fscanf(fd, "%h", a);
            end
            "O":
            begin
               want = 3;
               r    = $fscanf(fd, "%h %h %h", a, b, c);
            end
            default:
            begin
               $display("unknown command in pattern file, code %0d", ch);
               errors++;
               break;
            end
         endcase
         if (want != 0 && r != want)
         begin
            $display("pattern line for command %c has missing or bad fields", ch);
            errors++;
         end
         if (ch != "#" && ch != "\n" && ch != -1)
         begin
            cmd_q.push_back(byte'(ch));
            arg_a.push_back(a);
            arg_b.push_back(b);
            arg_c.push_back(c);
         end
      end
      $fclose(fd);
   endtask

   // ---------------------------------------------------------------------
   // apb transfers
   // ---------------------------------------------------------------------
   task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
      step();
      psel    = 1'b1;        // setup
      pwrite  = 1'b1;
      penable = 1'b0;
      paddr   = addr;
      pwdata  = data;
      step();
      penable = 1'b1;        // access phase commits at next edge
      step();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, input apb_data_t expected);
      step();
      psel    = 1'b1;
      pwrite  = 1'b0;
      penable = 1'b0;
      paddr   = addr;
      step();                // rdata captured on this edge
      penable = 1'b1;
      check_word("prdata", expected, prdata);
      step();
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apply_pins(input gpio_word_t pins, input gpio_word_t tse);
      step();
      gpio_pin_in      = pins;
      tri_state_enable = tse;
   endtask

   // outputs are combinational from registers and settle before the 1 ns skew
   task automatic check_outputs(input gpio_word_t oe_n, input gpio_word_t out, input logic irq);
      check_word("n_gpio_pin_oe", apb_data_t'(oe_n), apb_data_t'(n_gpio_pin_oe));
      check_word("gpio_pin_out", apb_data_t'(out), apb_data_t'(gpio_pin_out));
      check_word("gpio_int", apb_data_t'(irq), apb_data_t'(gpio_int));
   endtask

   // ---------------------------------------------------------------------
   // main sequence
   // ---------------------------------------------------------------------
   initial
   begin
      reset            = 1'b1;
      psel             = 1'b0;
      penable          = 1'b0;
      pwrite           = 1'b0;
      paddr            = '0;
      pwdata           = '0;
      gpio_pin_in      = '0;
      tri_state_enable = '0;
      load_patterns();
      if (cmd_q.size() == 0)
      begin
         $display("no commands were read from the pattern file");
         errors++;
      end
      loaded = 1'b1;
      repeat (2) @(posedge pclk);
      #1;
      reset = 1'b0;
      foreach (cmd_q[i])
      begin
         case (cmd_q[i])
            "W": apb_write(arg_a[i][5:0], arg_b[i]);
            "R": apb_read(arg_a[i][5:0], arg_b[i]);
            "P": apply_pins(arg_a[i][15:0], arg_b[i][15:0]);
            "N": repeat (arg_a[i]) step();
            "O": check_outputs(arg_a[i][15:0], arg_b[i][15:0], arg_c[i][0]);
            default: ;
         endcase
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // watchdog budget scales with the pattern length
   initial
   begin
      longint limit;
      wait (loaded);
      limit = longint'(cmd_q.size() + 1) * CYCLES_PER_LINE * CLK_PERIOD;
      #(limit);
      $display("timeout: pattern run did not finish within %0d ns", limit);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: rtl/gpio_lite.sv
module gpio_lite #(
   parameter int SYNC_STAGES = 2                  // input synchronizer depth, 2 or 3
) (
   // apb side
   input  logic                  pclk,            // peripheral bus clock
   input  logic                  reset,           // sync, active high
   input  logic                  psel,            // peripheral select
   input  logic                  penable,         // second phase of transfer
   input  logic                  pwrite,          // 1 = write
   input  gpio_pkg::apb_addr_t   paddr,
   input  gpio_pkg::apb_data_t   pwdata,
   output gpio_pkg::apb_data_t   prdata,          // upper half always zero

   // pin side
   input  gpio_pkg::gpio_word_t  gpio_pin_in,      // raw pin levels, async
   input  gpio_pkg::gpio_word_t  tri_state_enable, // forces drivers off
   output logic                  gpio_int,         // any masked status bit
   output gpio_pkg::gpio_word_t  n_gpio_pin_oe,    // active low drive enable
   output gpio_pkg::gpio_word_t  gpio_pin_out
);
   import gpio_pkg::*;

   gpio_bus_req_t bus_req;        // decoded access for the subunit
   gpio_word_t    rdata;          // registered read word
   gpio_word_t    pin_interrupt;  // per pin, already masked

   // ----------------------------------------------------------------------
   // apb strobe decode
   // ----------------------------------------------------------------------

   // read fires in setup so rdata is ready for the access phase
   assign bus_req.read  = psel & ~penable & ~pwrite;
   assign bus_req.write = psel &  penable &  pwrite;  // commit at end of access
   assign bus_req.addr  = paddr;
   assign bus_req.wdata = pwdata[GPIO_WIDTH-1:0];     // upper bits unused

   // ----------------------------------------------------------------------
   // read data and interrupt line
   // ----------------------------------------------------------------------

   // pad read word out to the bus width
   assign prdata = {{(APB_DATA_WIDTH-GPIO_WIDTH){1'b0}}, rdata};

   assign gpio_int = |pin_interrupt;   // single line to the interrupt ctrl

   // ----------------------------------------------------------------------
   // register file and pin logic
   // ----------------------------------------------------------------------
   gpio_lite_subunit #(
      .SYNC_STAGES      (SYNC_STAGES)
   ) i_gpio_lite_subunit (
      .pclk             (pclk),
      .reset            (reset),
      .bus_req          (bus_req),
      .pin_in           (gpio_pin_in),
      .tri_state_enable (tri_state_enable),
      .rdata            (rdata),
      .interrupt        (pin_interrupt),
      .pin_oe_n         (n_gpio_pin_oe),
      .pin_out          (gpio_pin_out)
   );

endmodule

// File: rtl/gpio_lite_subunit.sv
module gpio_lite_subunit #(
   parameter int SYNC_STAGES = 2                  // handed on to the detector
) (
   input  logic                    pclk,
   input  logic                    reset,            // sync, active high
   input  gpio_pkg::gpio_bus_req_t bus_req,          // decoded apb strobes
   input  gpio_pkg::gpio_word_t    pin_in,           // raw pins
   input  gpio_pkg::gpio_word_t    tri_state_enable, // 1 = driver off
   output gpio_pkg::gpio_word_t    rdata,            // held until next read
   output gpio_pkg::gpio_word_t    interrupt,        // status & mask
   output gpio_pkg::gpio_word_t    pin_oe_n,
   output gpio_pkg::gpio_word_t    pin_out
);
   import gpio_pkg::*;

   // programmable registers
   gpio_word_t    out_value;
   gpio_word_t    out_enable;
   gpio_word_t    int_mask;
   gpio_word_t    int_type;       // 1 edge, 0 level
   gpio_word_t    int_polarity;

   // detector interface
   gpio_int_cfg_t int_cfg;
   gpio_word_t    status_clear;   // w1c bits, only on a status write
   gpio_word_t    pin_sync;
   gpio_word_t    int_status;

   gpio_word_t    read_word;      // mux output before the rdata flop

   // ----------------------------------------------------------------------
   // register writes
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         out_value    <= '0;
         out_enable   <= '0;     // all pins tri-stated out of reset
         int_mask     <= '0;
         int_type     <= '0;
         int_polarity <= '0;
      end
      else if (bus_req.write)
      begin
         case (bus_req.addr)
            ADDR_OUT_VALUE:    out_value    <= bus_req.wdata;
            ADDR_OUT_ENABLE:   out_enable   <= bus_req.wdata;
            ADDR_INT_MASK:     int_mask     <= bus_req.wdata;
            ADDR_INT_TYPE:     int_type     <= bus_req.wdata;
            ADDR_INT_POLARITY: int_polarity <= bus_req.wdata;
            default:           ;          // pin value ro, status handled below
         endcase
      end
   end

   // status write goes to the detector as a clear mask
   assign status_clear = (bus_req.write && bus_req.addr == ADDR_INT_STATUS) ?
                         bus_req.wdata : '0;

   // ----------------------------------------------------------------------
   // read path
   // ----------------------------------------------------------------------
   always_comb
   begin
      case (bus_req.addr)
         ADDR_OUT_VALUE:    read_word = out_value;
         ADDR_OUT_ENABLE:   read_word = out_enable;
         ADDR_PIN_VALUE:    read_word = pin_sync;      // synced, not raw
         ADDR_INT_MASK:     read_word = int_mask;
         ADDR_INT_TYPE:     read_word = int_type;
         ADDR_INT_POLARITY: read_word = int_polarity;
         ADDR_INT_STATUS:   read_word = int_status;
         default:           read_word = '0;            // unmapped reads 0
      endcase
   end

   // captured at end of setup, valid through access
   always_ff @(posedge pclk)
   begin
      if (reset)
         rdata <= '0;
      else if (bus_req.read)
         rdata <= read_word;
   end

   // ----------------------------------------------------------------------
   // pin drive
   // ----------------------------------------------------------------------
   assign pin_out  = out_value;
   assign pin_oe_n = ~(out_enable & ~tri_state_enable);   // override wins

   // ----------------------------------------------------------------------
   // interrupt detect
   // ----------------------------------------------------------------------
   assign int_cfg.mask      = int_mask;
   assign int_cfg.edge_type = int_type;
   assign int_cfg.polarity  = int_polarity;

   gpio_int_detect #(
      .SYNC_STAGES  (SYNC_STAGES)
   ) i_gpio_int_detect (
      .pclk         (pclk),
      .reset        (reset),
      .pin_in       (pin_in),
      .int_cfg      (int_cfg),
      .status_clear (status_clear),
      .pin_sync     (pin_sync),
      .int_status   (int_status)
   );

   assign interrupt = int_status & int_mask;   // unmasking old status fires at once

endmodule

// File: rtl/gpio_int_detect.sv
module gpio_int_detect #(
   parameter int SYNC_STAGES = 2                  // flops before pin_sync, 2 or 3
) (
   input  logic                    pclk,
   input  logic                    reset,         // sync, active high
   input  gpio_pkg::gpio_word_t    pin_in,        // async pin levels
   input  gpio_pkg::gpio_int_cfg_t int_cfg,
   input  gpio_pkg::gpio_word_t    status_clear,  // 1 = clear that bit
   output gpio_pkg::gpio_word_t    pin_sync,      // pins in the pclk domain
   output gpio_pkg::gpio_word_t    int_status     // sticky per pin status
);
   import gpio_pkg::*;

   gpio_word_t sync_q [SYNC_STAGES];   // [0] samples the raw pins
   gpio_word_t pin_prev;               // pin_sync one cycle back
   gpio_word_t rise;
   gpio_word_t fall;
   gpio_word_t edge_event;
   gpio_word_t level_event;
   gpio_word_t int_event;

   // ----------------------------------------------------------------------
   // synchronizer
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         for (int i = 0; i < SYNC_STAGES; i++)
            sync_q[i] <= '0;
         pin_prev <= '0;
      end
      else
      begin
         sync_q[0] <= pin_in;
         for (int i = 1; i < SYNC_STAGES; i++)
            sync_q[i] <= sync_q[i-1];   // shift toward the output
         pin_prev <= pin_sync;          // history for edge compare
      end
   end

   assign pin_sync = sync_q[SYNC_STAGES-1];

   // ----------------------------------------------------------------------
   // event detect
   // ----------------------------------------------------------------------
   assign rise = pin_sync & ~pin_prev;
   assign fall = ~pin_sync & pin_prev;

   // polarity picks the direction per pin
   assign edge_event  = (rise & int_cfg.polarity) | (fall & ~int_cfg.polarity);
   assign level_event = ~(pin_sync ^ int_cfg.polarity);   // pin at active level

   // only masked pins may set status
   assign int_event = int_cfg.mask &
                      ((edge_event & int_cfg.edge_type) |
                       (level_event & ~int_cfg.edge_type));

   // ----------------------------------------------------------------------
   // sticky status
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk)
   begin
      if (reset)
         int_status <= '0;
      else
         int_status <= (int_status & ~status_clear) | int_event;   // set beats clear
   end

endmodule

// File: rtl/gpio_pkg.sv
package gpio_pkg;

   // ----------------------------------------------------------------------
   // widths
   // ----------------------------------------------------------------------
   localparam int GPIO_WIDTH     = 16;   // pins on the port
   localparam int APB_ADDR_WIDTH = 6;    // byte address, 16 word slots
   localparam int APB_DATA_WIDTH = 32;

   typedef logic [GPIO_WIDTH-1:0]     gpio_word_t;   // one bit per pin
   typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
   typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

   // ----------------------------------------------------------------------
   // register map
   // ----------------------------------------------------------------------
   localparam apb_addr_t ADDR_OUT_VALUE    = 6'h00;  // rw, pin drive value
   localparam apb_addr_t ADDR_OUT_ENABLE   = 6'h04;  // rw, 1 = drive pin
   localparam apb_addr_t ADDR_PIN_VALUE    = 6'h08;  // ro, synced pins
   localparam apb_addr_t ADDR_INT_MASK     = 6'h0C;  // rw, 1 = irq allowed
   localparam apb_addr_t ADDR_INT_TYPE     = 6'h10;  // rw, 1 = edge, 0 = level
   localparam apb_addr_t ADDR_INT_POLARITY = 6'h14;  // rw, 1 = rise/high
   localparam apb_addr_t ADDR_INT_STATUS   = 6'h18;  // read status, write 1 clears

   // ----------------------------------------------------------------------
   // bundles
   // ----------------------------------------------------------------------

   // decoded apb access, top level to subunit
   typedef struct packed {
      logic       read;    // setup phase of a read
      logic       write;   // access phase of a write
      apb_addr_t  addr;
      gpio_word_t wdata;   // low half of pwdata
   } gpio_bus_req_t;

   // interrupt setup, subunit to detector
   typedef struct packed {
      gpio_word_t mask;       // pins allowed to raise status
      gpio_word_t edge_type;  // 1 edge, 0 level
      gpio_word_t polarity;   // 1 rising/high, 0 falling/low
   } gpio_int_cfg_t;

endpackage
